//--- include/scv_mem_defines.svh
//////////////////////////////////////////////////////////////////////
// sizes, clock divide and open-bus fill for the memory side
//////////////////////////////////////////////////////////////////////

`ifndef SCV_MEM_DEFINES_SVH
`define SCV_MEM_DEFINES_SVH

// boot ROM is 4 KiB at 0000
`define SCV_ROM_AW 12

// internal work RAM is 128 bytes at FF80
`define SCV_WRAM_AW 7

// master clock cycles per CPU clock cycle
// master clock is twice the video crystal, CPU runs at CLK / 14
`define SCV_CLK_DIV 14

// byte seen on the data bus when nothing drives it
`define SCV_OPEN_BUS 8'hFF

`endif

//--- hw/scv_pkg.sv
//////////////////////////////////////////////////////////////////////
// shared enums and packed structs for the memory side
//////////////////////////////////////////////////////////////////////

`include "scv_mem_defines.svh"

package scv_pkg;

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } bus_op_e;

  typedef enum logic [1:0] {
    REGION_ROM  = 2'd0,
    REGION_WRAM = 2'd1,
    REGION_OPEN = 2'd2
  } region_e;

  typedef enum logic [1:0] {
    ST_IDLE    = 2'd0,
    ST_WAIT_T1 = 2'd1,   // waiting for the next phase 1 rise
    ST_ADDR    = 2'd2,
    ST_DATA    = 2'd3
  } bus_state_e;

  typedef struct packed {
    bus_op_e     op;
    logic [15:0] addr;
    logic [7:0]  wdata;
  } bus_req_t;

  typedef struct packed {
    logic                   valid;
    logic [`SCV_ROM_AW-1:0] addr;
    logic [7:0]             data;
  } rom_init_t;

  // single-cycle strobes on the CPU clock edges
  typedef struct packed {
    logic cp1_pos;
    logic cp2_pos;
    logic cp2_neg;
  } phase_t;

endpackage

//--- hw/scv_clkgen.sv
//////////////////////////////////////////////////////////////////////
// divide-by-14 phase counter, CPU phase strobes and video clock enable
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "scv_mem_defines.svh"

module scv_clkgen (
  input  logic            CLK,
  input  logic            rst_n_i,
  output scv_pkg::phase_t phase_o,
  output logic            vdc_ce_o
);

  localparam int CW = $clog2(`SCV_CLK_DIV);

  logic [CW-1:0] cnt_q;

  always_ff @(posedge CLK) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else if (cnt_q == CW'(`SCV_CLK_DIV - 1)) begin
      cnt_q <= '0;                             // wrap after 13
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // strobe decode

  assign phase_o.cp2_neg = (cnt_q == CW'(0));
  assign phase_o.cp1_pos = (cnt_q == CW'(2));
  assign phase_o.cp2_pos = (cnt_q == CW'(6));

  // video clock is CLK / 7, two enables per CPU cycle
  assign vdc_ce_o = (cnt_q == CW'(2)) || (cnt_q == CW'(9));

endmodule

//--- hw/scv_bus_fsm.sv
//////////////////////////////////////////////////////////////////////
// bus cycle sequencer, paces one request on the CPU phase strobes
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module scv_bus_fsm (
  input  logic              CLK,
  input  logic              rst_n_i,
  input  logic              req_i,
  input  scv_pkg::bus_req_t req_data_i,
  input  scv_pkg::phase_t   phase_i,
  input  scv_pkg::region_e  region_i,
  input  logic [7:0]        rdata_mux_i,
  output logic [15:0]       addr_o,
  output logic [7:0]        wdata_o,
  output logic              wram_we_o,
  output logic              busy_o,
  output logic              done_o,
  output logic [7:0]        rdata_o
);

  scv_pkg::bus_state_e state_q;
  scv_pkg::bus_state_e state_d;
  scv_pkg::bus_req_t   req_q;   // held for the whole bus cycle
  logic [7:0]          rdata_q;
  logic                done_q;
  logic                accept;
  logic                end_cycle;

  assign accept    = (state_q == scv_pkg::ST_IDLE) && req_i;
  assign end_cycle = (state_q == scv_pkg::ST_DATA) && phase_i.cp2_neg;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      scv_pkg::ST_IDLE:    if (req_i) state_d = scv_pkg::ST_WAIT_T1;
      scv_pkg::ST_WAIT_T1: if (phase_i.cp1_pos) state_d = scv_pkg::ST_ADDR;
      scv_pkg::ST_ADDR:    if (phase_i.cp2_pos) state_d = scv_pkg::ST_DATA;
      scv_pkg::ST_DATA:    if (phase_i.cp2_neg) state_d = scv_pkg::ST_IDLE;
      default:             state_d = scv_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (!rst_n_i) begin
      state_q <= scv_pkg::ST_IDLE;
      done_q  <= 1'b0;
      rdata_q <= 8'h00;
    end else begin
      state_q <= state_d;
      done_q  <= end_cycle;
      // writes leave the last read byte in place
      if (end_cycle && (req_q.op == scv_pkg::OP_READ)) begin
        rdata_q <= rdata_mux_i;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (accept) begin
      req_q <= req_data_i;
    end
  end

  // write strobe lands on the phase 2 rise, ROM and open bus writes are dropped
  assign wram_we_o = (state_q == scv_pkg::ST_ADDR) && phase_i.cp2_pos &&
                     (req_q.op == scv_pkg::OP_WRITE) &&
                     (region_i == scv_pkg::REGION_WRAM);

  assign addr_o  = req_q.addr;
  assign wdata_o = req_q.wdata;
  assign busy_o  = (state_q != scv_pkg::ST_IDLE) || done_q;  // stays up through done
  assign done_o  = done_q;
  assign rdata_o = rdata_q;

endmodule

//--- hw/scv_bus_decode.sv
//////////////////////////////////////////////////////////////////////
// address decoder and read data mux with open-bus fill
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "scv_mem_defines.svh"

module scv_bus_decode (
  input  logic [15:0]      addr_i,
  input  logic [7:0]       rom_data_i,
  input  logic [7:0]       wram_data_i,
  output scv_pkg::region_e region_o,
  output logic [7:0]       rdata_o
);

  logic rom_sel;
  logic wram_sel;

  assign rom_sel  = (addr_i[15:12] == 4'h0);   // 0000-0FFF
  assign wram_sel = &addr_i[15:7];             // FF80-FFFF

  always_comb begin
    if (rom_sel) begin
      region_o = scv_pkg::REGION_ROM;
    end else if (wram_sel) begin
      region_o = scv_pkg::REGION_WRAM;
    end else begin
      region_o = scv_pkg::REGION_OPEN;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read mux

  always_comb begin
    unique case (region_o)
      scv_pkg::REGION_ROM:  rdata_o = rom_data_i;
      scv_pkg::REGION_WRAM: rdata_o = wram_data_i;
      default:              rdata_o = `SCV_OPEN_BUS;  // nothing drives the bus
    endcase
  end

endmodule

//--- hw/scv_bootrom.sv
//////////////////////////////////////////////////////////////////////
// 4 KiB boot ROM, byte load port and asynchronous read
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "scv_mem_defines.svh"

module scv_bootrom (
  input  logic                   CLK,
  input  scv_pkg::rom_init_t     init_i,
  input  logic [`SCV_ROM_AW-1:0] addr_i,
  output logic [7:0]             data_o
);

  localparam int DEPTH = 1 << `SCV_ROM_AW;

  logic [7:0] mem [DEPTH];

  // one byte per valid beat, loaded before the CPU runs
  always_ff @(posedge CLK) begin
    if (init_i.valid) begin
      mem[init_i.addr] <= init_i.data;
    end
  end

  assign data_o = mem[addr_i];   // mask ROM style read, no clock

endmodule

//--- hw/scv_wram.sv
//////////////////////////////////////////////////////////////////////
// work RAM, registered read and write enable
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "scv_mem_defines.svh"

module scv_wram #(
  parameter int AW = `SCV_WRAM_AW
) (
  input  logic          CLK,
  input  logic          we_i,
  input  logic [AW-1:0] addr_i,
  input  logic [7:0]    wdata_i,
  output logic [7:0]    rdata_o
);

  localparam int DEPTH = 1 << AW;

  // starts cleared so early reads are defined
  logic [7:0] mem [DEPTH] = '{default: 8'h00};
  logic [7:0] rdata_q;

  always_ff @(posedge CLK) begin
    rdata_q <= mem[addr_i];        // read every edge, old data on a write
    if (we_i) begin
      mem[addr_i] <= wdata_i;
    end
  end

  assign rdata_o = rdata_q;

endmodule

//--- hw/scv_mem_top.sv
//////////////////////////////////////////////////////////////////////
// memory side top, clock generator, bus sequencer, decoder, ROM, RAM
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "scv_mem_defines.svh"

module scv_mem_top (
  input  logic               CLK,
  input  logic               rst_n_i,
  input  logic               req_i,
  input  scv_pkg::bus_req_t  req_data_i,
  input  scv_pkg::rom_init_t rom_init_i,
  output logic               busy_o,
  output logic               done_o,
  output logic [7:0]         rdata_o,
  output logic               vdc_ce_o
);

  scv_pkg::phase_t  phase;
  scv_pkg::region_e region;
  logic [15:0]      bus_addr;
  logic [7:0]       bus_wdata;
  logic [7:0]       rom_data;
  logic [7:0]       wram_data;
  logic [7:0]       rdata_mux;
  logic             wram_we;

  scv_clkgen u_clkgen (
    .CLK      (CLK),
    .rst_n_i  (rst_n_i),
    .phase_o  (phase),
    .vdc_ce_o (vdc_ce_o)
  );

  scv_bus_fsm u_bus_fsm (
    .CLK         (CLK),
    .rst_n_i     (rst_n_i),
    .req_i       (req_i),
    .req_data_i  (req_data_i),
    .phase_i     (phase),
    .region_i    (region),
    .rdata_mux_i (rdata_mux),
    .addr_o      (bus_addr),
    .wdata_o     (bus_wdata),
    .wram_we_o   (wram_we),
    .busy_o      (busy_o),
    .done_o      (done_o),
    .rdata_o     (rdata_o)
  );

  scv_bus_decode u_bus_decode (
    .addr_i      (bus_addr),
    .rom_data_i  (rom_data),
    .wram_data_i (wram_data),
    .region_o    (region),
    .rdata_o     (rdata_mux)
  );

  //////////////////////////////////////////////////////////////////////
  // memories see only the low address bits

  scv_bootrom u_bootrom (
    .CLK    (CLK),
    .init_i (rom_init_i),
    .addr_i (bus_addr[`SCV_ROM_AW-1:0]),
    .data_o (rom_data)
  );

  scv_wram #(.AW(`SCV_WRAM_AW)) u_wram (
    .CLK     (CLK),
    .we_i    (wram_we),
    .addr_i  (bus_addr[`SCV_WRAM_AW-1:0]),
    .wdata_i (bus_wdata),
    .rdata_o (wram_data)
  );

endmodule

//--- bench/scv_mem_assert.sv
//////////////////////////////////////////////////////////////////////
// bus sequencer assertions on request, done and write strobe rules
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module scv_mem_assert (
  input logic                CLK,
  input logic                rst_n_i,
  input logic                req_i,
  input logic                busy_i,
  input logic                done_i,
  input logic                wram_we_i,
  input scv_pkg::bus_state_e state_i
);

  int req_fails  = 0;
  int done_fails = 0;
  int we_fails   = 0;
  int fail_cnt;

  // the master waits for busy to drop since there is no back-pressure
  no_req_while_busy: assert property (@(posedge CLK) disable iff (!rst_n_i)
    !(req_i && busy_i))
    else begin
      $error("request issued while the bus is busy");
      req_fails++;
    end

  done_single_cycle: assert property (@(posedge CLK) disable iff (!rst_n_i)
    !(done_i && $past(done_i)))
    else begin
      $error("done pulse lasted two cycles");
      done_fails++;
    end

  // strobe sits on the last address phase cycle, data phase follows
  we_only_in_addr: assert property (@(posedge CLK) disable iff (!rst_n_i)
    wram_we_i |=> ($past(state_i) == scv_pkg::ST_ADDR) &&
                  (state_i == scv_pkg::ST_DATA))
    else begin
      $error("work RAM write strobe not on the address to data phase step");
      we_fails++;
    end

  assign fail_cnt = req_fails + done_fails + we_fails;

endmodule

//--- bench/scv_mem_checker.sv
//////////////////////////////////////////////////////////////////////
// reference model of ROM and work RAM, read data and timing checks
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "scv_mem_defines.svh"

module scv_mem_checker (
  input  logic               CLK,
  input  logic               rst_n_i,
  input  logic               req_i,
  input  scv_pkg::bus_req_t  req_data_i,
  input  scv_pkg::rom_init_t rom_init_i,
  input  logic               busy_i,
  input  logic               done_i,
  input  logic [7:0]         rdata_i,
  input  logic               vdc_ce_i,
  output int                 data_err_o,
  output int                 proto_err_o,
  output int                 clk_err_o
);

  localparam int MAX_LATENCY = 28;
  localparam int CE_SPACING  = 7;

  logic [7:0]        rom_model [1 << `SCV_ROM_AW];
  logic [7:0]        ram_model [1 << `SCV_WRAM_AW] = '{default: 8'h00};
  scv_pkg::bus_req_t cur_req;
  logic              pending    = 1'b0;
  int                wait_cycles = 0;
  logic [7:0]        last_rdata = 8'h00;   // rdata_o holds across writes
  logic              reset_seen = 1'b0;
  logic              ce_seen    = 1'b0;
  logic              ce_prev    = 1'b0;
  int                ce_gap     = 0;
  int                data_errs  = 0;
  int                proto_errs = 0;
  int                clk_errs   = 0;

  // memory map: ROM 0000-0FFF, work RAM FF80-FFFF, the rest floats high
  function automatic logic [7:0] expected_byte(logic [15:0] addr);
    if (addr < 16'h1000) begin
      return rom_model[addr[`SCV_ROM_AW-1:0]];
    end else if (addr >= 16'hFF80) begin
      return ram_model[addr[`SCV_WRAM_AW-1:0]];
    end
    return 8'hFF;
  endfunction

  task automatic check_done();
    logic [7:0] exp;
    if (cur_req.op == scv_pkg::OP_READ) begin
      exp = expected_byte(cur_req.addr);
      if (rdata_i !== exp) begin
        $display("FAILED rdata_o: got %h, expected %h, addr %h", rdata_i, exp, cur_req.addr);
        data_errs++;
      end
      last_rdata = exp;
    end else begin
      if (rdata_i !== last_rdata) begin
        $display("FAILED rdata_o: got %h after write, expected held %h, addr %h",
                 rdata_i, last_rdata, cur_req.addr);
        data_errs++;
      end
      if (cur_req.addr >= 16'hFF80) begin
        ram_model[cur_req.addr[`SCV_WRAM_AW-1:0]] = cur_req.wdata;
      end
    end
  endtask

  task automatic check_bus();
    if (pending) begin
      wait_cycles++;
      if (!busy_i) begin
        $display("protocol: busy_o low %0d cycles after request to %h",
                 wait_cycles, cur_req.addr);
        proto_errs++;
      end
      if (done_i) begin
        check_done();
        pending = 1'b0;
      end else if (wait_cycles >= MAX_LATENCY) begin
        $display("protocol: no done_o within %0d cycles of request to %h",
                 MAX_LATENCY, cur_req.addr);
        proto_errs++;
        pending = 1'b0;
      end
    end else if (done_i) begin
      $display("protocol: done_o pulse with no request outstanding");
      proto_errs++;
    end
    if (req_i) begin
      if (pending) begin
        $display("protocol: new request while the previous one is outstanding");
        proto_errs++;
      end
      cur_req     = req_data_i;
      pending     = 1'b1;
      wait_cycles = 0;
    end
  endtask

  task automatic check_clock_enable();
    ce_gap++;
    if (vdc_ce_i) begin
      if (ce_prev) begin
        $display("clock: vdc_ce_o stayed high for more than one cycle");
        clk_errs++;
      end else if (ce_seen && ce_gap != CE_SPACING) begin
        $display("clock: vdc_ce_o pulses %0d cycles apart, expected %0d", ce_gap, CE_SPACING);
        clk_errs++;
      end
      ce_seen = 1'b1;
      ce_gap  = 0;
    end
    ce_prev = vdc_ce_i;
  endtask

  //////////////////////////////////////////////////////////////////////
  // sample everything on the rising edge, like the DUT flops do

  always @(posedge CLK) begin
    if (rom_init_i.valid) begin
      rom_model[rom_init_i.addr] = rom_init_i.data;
    end
    if (!rst_n_i) begin
      if (reset_seen && (busy_i || done_i)) begin
        $display("reset: busy_o or done_o active while reset is held");
        proto_errs++;
      end
      if (reset_seen && rdata_i !== 8'h00) begin
        $display("FAILED rdata_o: got %h during reset, expected %h", rdata_i, 8'h00);
        data_errs++;
      end
      reset_seen = 1'b1;       // outputs are defined after the first reset edge
      pending    = 1'b0;
      last_rdata = 8'h00;
      ce_seen    = 1'b0;
      ce_prev    = 1'b0;
      ce_gap     = 0;
    end else begin
      check_clock_enable();
      check_bus();
    end
  end

  assign data_err_o  = data_errs;
  assign proto_err_o = proto_errs;
  assign clk_err_o   = clk_errs;

endmodule

//--- bench/scv_mem_tb.sv
//////////////////////////////////////////////////////////////////////
// testbench top, clock, reset, ROM load, random bus traffic, run end
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "scv_mem_defines.svh"

module scv_mem_tb;

  localparam int SEED        = 64;
  localparam int NUM_TXN     = 400;
  localparam int ROM_BYTES   = 1 << `SCV_ROM_AW;
  localparam int CYCLE_LIMIT = NUM_TXN * 30 + ROM_BYTES + 100;

  logic               CLK;
  logic               rst_n_i;
  logic               req_i;
  scv_pkg::bus_req_t  req_data_i;
  scv_pkg::rom_init_t rom_init_i;
  logic               busy_o;
  logic               done_o;
  logic [7:0]         rdata_o;
  logic               vdc_ce_o;
  int                 data_errs;
  int                 proto_errs;
  int                 clk_errs;
  int                 cycles = 0;

  scv_mem_top dut0 (
    .CLK        (CLK),
    .rst_n_i    (rst_n_i),
    .req_i      (req_i),
    .req_data_i (req_data_i),
    .rom_init_i (rom_init_i),
    .busy_o     (busy_o),
    .done_o     (done_o),
    .rdata_o    (rdata_o),
    .vdc_ce_o   (vdc_ce_o)
  );

  scv_mem_checker chk0 (
    .CLK         (CLK),
    .rst_n_i     (rst_n_i),
    .req_i       (req_i),
    .req_data_i  (req_data_i),
    .rom_init_i  (rom_init_i),
    .busy_i      (busy_o),
    .done_i      (done_o),
    .rdata_i     (rdata_o),
    .vdc_ce_i    (vdc_ce_o),
    .data_err_o  (data_errs),
    .proto_err_o (proto_errs),
    .clk_err_o   (clk_errs)
  );

  bind scv_bus_fsm scv_mem_assert fsm_assert0 (
    .CLK       (CLK),
    .rst_n_i   (rst_n_i),
    .req_i     (req_i),
    .busy_i    (busy_o),
    .done_i    (done_o),
    .wram_we_i (wram_we_o),
    .state_i   (state_q)
  );

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  // hard stop in case the DUT never lets go of busy_o
  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Checks failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus, all driven on the falling edge

  task automatic load_rom();
    for (int i = 0; i < ROM_BYTES; i++) begin
      rom_init_i = '{valid: 1'b1, addr: i[`SCV_ROM_AW-1:0], data: 8'($urandom)};
      @(negedge CLK);
    end
    rom_init_i = '0;
  endtask

  // 40% ROM, 40% work RAM, 20% unmapped
  function automatic logic [15:0] random_addr();
    int pick;
    pick = $urandom_range(9, 0);
    if (pick < 4) begin
      return 16'($urandom_range(16'h0FFF, 0));
    end else if (pick < 8) begin
      return 16'hFF80 + 16'($urandom_range(127, 0));
    end
    return 16'($urandom_range(16'hFF7F, 16'h1000));
  endfunction

  task automatic bus_access(input scv_pkg::bus_op_e op, input logic [15:0] addr,
                            input logic [7:0] wdata);
    @(negedge CLK);
    while (busy_o) begin
      @(negedge CLK);
    end
    req_i      = 1'b1;                      // single-cycle request strobe
    req_data_i = '{op: op, addr: addr, wdata: wdata};
    @(negedge CLK);
    req_i      = 1'b0;
  endtask

  initial begin
    scv_pkg::bus_op_e op;
    int               total;
    rst_n_i    = 1'b0;
    req_i      = 1'b0;
    req_data_i = '0;
    rom_init_i = '0;
    void'($urandom(SEED));
    repeat (5) @(negedge CLK);
    rst_n_i = 1'b1;
    load_rom();
    for (int n = 0; n < NUM_TXN; n++) begin
      op = ($urandom_range(1, 0) == 1) ? scv_pkg::OP_WRITE : scv_pkg::OP_READ;
      bus_access(op, random_addr(), 8'($urandom));
    end
    @(negedge CLK);
    while (busy_o) begin
      @(negedge CLK);
    end
    repeat (4) @(negedge CLK);
    total = data_errs + proto_errs + clk_errs + dut0.u_bus_fsm.fsm_assert0.fail_cnt;
    $display("error counts: data %0d, protocol %0d, clock %0d, assertion %0d",
             data_errs, proto_errs, clk_errs, dut0.u_bus_fsm.fsm_assert0.fail_cnt);
    if (total == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- scv_mem.f
+incdir+include
hw/scv_pkg.sv
hw/scv_clkgen.sv
hw/scv_bus_fsm.sv
hw/scv_bus_decode.sv
hw/scv_bootrom.sv
hw/scv_wram.sv
hw/scv_mem_top.sv
bench/scv_mem_assert.sv
bench/scv_mem_checker.sv
bench/scv_mem_tb.sv

//--- Makefile
# Verilator build and run for the scv_mem memory side

VERILATOR  ?= verilator
TOP        ?= scv_mem_tb
FILELIST   ?= scv_mem.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert
SIM_ARGS   ?= +verilator+error+limit+1000
PASS_MSG   ?= All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# pass only if the testbench printed the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
